/* Makefile */
TOP := rv_core_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		-f sim.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qx "TEST RESULT: PASS" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

/* design/rv_alu.sv */
// rv_alu: shared-adder ALU for add, subtract, logic, signed and unsigned compare, and shifts
`default_nettype none
`include "rv_core_config.svh"

module rv_alu (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  rv_core_pkg::alu_op_e alu_op,
    output logic [`RV_XLEN-1:0] result
);
    import rv_core_pkg::*;

    localparam int SHIFT_W = $clog2(`RV_XLEN);

    logic                is_sub;
    logic                overflow;
    logic                slt_res, sltu_res;
    logic [`RV_XLEN-1:0] b_eff, sum;
    logic [SHIFT_W-1:0]  shamt;

    // compares reuse the subtractor
    assign is_sub = (alu_op == ALU_SUB) || (alu_op == ALU_SLT) || (alu_op == ALU_SLTU);
    assign b_eff  = b ^ {`RV_XLEN{is_sub}};
    assign sum    = a + b_eff + {{(`RV_XLEN-1){1'b0}}, is_sub};

    assign overflow = (a[`RV_XLEN-1] == b_eff[`RV_XLEN-1]) &&
                      (sum[`RV_XLEN-1] != a[`RV_XLEN-1]);
    assign slt_res  = sum[`RV_XLEN-1] ^ overflow;

    // same signs: difference sign decides, else the operand with msb clear is smaller
    always_comb begin
        case ({a[`RV_XLEN-1], b[`RV_XLEN-1]})
            2'b01:   sltu_res = 1'b1;
            2'b10:   sltu_res = 1'b0;
            default: sltu_res = sum[`RV_XLEN-1];
        endcase
    end

    assign shamt = b[SHIFT_W-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD, ALU_SUB: result = sum;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(`RV_XLEN-1){1'b0}}, slt_res};
            ALU_SLTU: result = {{(`RV_XLEN-1){1'b0}}, sltu_res};
            ALU_SLL:  result = a << shamt;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* design/rv_control.sv */
// rv_control: RV32I decoder producing the datapath selects, ALU operation and write enable
`default_nettype none

module rv_control (
    input  logic                    reset,
    input  rv_core_pkg::inst_u      inst,
    output rv_core_pkg::alu_op_e    alu_op,
    output rv_core_pkg::src_a_sel_e src_a_sel,
    output logic                    use_imm,
    output rv_core_pkg::imm_sel_e   imm_sel,
    output rv_core_pkg::wb_sel_e    wb_sel,
    output rv_core_pkg::pc_mode_e   pc_mode,
    output logic [2:0]              branch_funct,
    output logic                    reg_we
);
    import rv_core_pkg::*;

    opcode_e opcode;
    alu_op_e arith_op;
    logic    alt_bit;
    logic    writes_rd;

    assign opcode       = opcode_e'(inst.r.opcode);
    assign alt_bit      = inst.r.funct7[5]; // selects sub and sra
    assign branch_funct = inst.r.funct3;

    // funct3 to alu operation, shared by reg-reg and reg-imm forms
    always_comb begin
        case (inst.r.funct3)
            3'b000: begin
                if (opcode == OPC_OP && alt_bit) begin
                    arith_op = ALU_SUB;
                end else begin
                    arith_op = ALU_ADD;
                end
            end
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = alt_bit ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            default: arith_op = ALU_AND;
        endcase
    end

    always_comb begin
        alu_op    = ALU_ADD;
        src_a_sel = SRC_A_RS1;
        use_imm   = 1'b0;
        imm_sel   = IMM_I;
        wb_sel    = WB_ALU;
        pc_mode   = PC_SEQ;
        writes_rd = 1'b0;
        case (opcode)
            OPC_OP: begin
                alu_op    = arith_op;
                writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op    = arith_op;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            OPC_LUI: begin
                src_a_sel = SRC_A_ZERO;
                use_imm   = 1'b1;
                imm_sel   = IMM_U;
                writes_rd = 1'b1;
            end
            OPC_AUIPC: begin
                src_a_sel = SRC_A_PC;
                use_imm   = 1'b1;
                imm_sel   = IMM_U;
                writes_rd = 1'b1;
            end
            OPC_JAL: begin
                imm_sel   = IMM_J;
                wb_sel    = WB_PC4; // link address
                pc_mode   = PC_JAL;
                writes_rd = 1'b1;
            end
            OPC_JALR: begin
                wb_sel    = WB_PC4;
                pc_mode   = PC_JALR;
                writes_rd = 1'b1;
            end
            OPC_BRANCH: begin
                imm_sel = IMM_B;
                pc_mode = PC_BRANCH;
            end
            default: ; // load, store, system and unknown retire as no-ops
        endcase
    end

    assign reg_we = writes_rd && (inst.r.rd != 5'd0) && !reset;

endmodule

`default_nettype wire

/* design/rv_core_config.svh */
// rv_core configuration: data width, register count and reset vector of the RV32I core
`ifndef RV_CORE_CONFIG_SVH
`define RV_CORE_CONFIG_SVH

// data and address width
`define RV_XLEN 32

// architectural integer registers, x0 included
`define RV_REG_COUNT 32

// first fetch address after reset
`define RV_RESET_PC 32'h8000_0000

// register index width follows from the count
`define RV_REG_AW $clog2(`RV_REG_COUNT)

`endif

/* design/rv_core_pkg.sv */
// rv_core_pkg: instruction views and decode select encodings shared by the core
`default_nettype none

package rv_core_pkg;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    // one instruction word, three field layouts
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } inst_u;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {IMM_I, IMM_B, IMM_U, IMM_J} imm_sel_e;

    typedef enum logic [1:0] {SRC_A_RS1, SRC_A_PC, SRC_A_ZERO} src_a_sel_e;

    typedef enum logic {WB_ALU, WB_PC4} wb_sel_e;

    // seq, conditional branch, pc-relative jump, register jump
    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JAL, PC_JALR} pc_mode_e;

endpackage

`default_nettype wire

/* design/rv_core_top.sv */
// rv_core_top: single-cycle RV32I integer core with a combinational fetch port and retire port
`default_nettype none
`include "rv_core_config.svh"

module rv_core_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [31:0]         imem_data,
    output logic [31:0]         imem_addr,
    output logic                retire_we,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data
);
    import rv_core_pkg::*;

    inst_u              inst;
    alu_op_e            alu_op;
    src_a_sel_e         src_a_sel;
    imm_sel_e           imm_sel;
    wb_sel_e            wb_sel;
    pc_mode_e           pc_mode;
    logic               use_imm;
    logic               reg_we;
    logic [2:0]         branch_funct;
    logic [`RV_XLEN-1:0] imm, rs1_data, rs2_data;
    logic [`RV_XLEN-1:0] alu_a, alu_b, alu_result;
    logic [`RV_XLEN-1:0] pc, pc_plus4, wb_data;

    assign inst = imem_data;

    rv_control u_control (
        .reset(reset), .inst(inst), .alu_op(alu_op), .src_a_sel(src_a_sel),
        .use_imm(use_imm), .imm_sel(imm_sel), .wb_sel(wb_sel), .pc_mode(pc_mode),
        .branch_funct(branch_funct), .reg_we(reg_we)
    );

    rv_imm_gen u_imm_gen (.inst(inst), .imm_sel(imm_sel), .imm(imm));

    rv_regfile u_regfile (
        .clk(clk), .reset(reset), .we(reg_we), .waddr(inst.r.rd),
        .raddr1(inst.r.rs1), .raddr2(inst.r.rs2), .wdata(wb_data),
        .rdata1(rs1_data), .rdata2(rs2_data)
    );

    always_comb begin
        case (src_a_sel)
            SRC_A_RS1: alu_a = rs1_data;
            SRC_A_PC:  alu_a = pc;
            default:   alu_a = '0; // lui adds to zero
        endcase
    end

    assign alu_b = use_imm ? imm : rs2_data;

    rv_alu u_alu (.a(alu_a), .b(alu_b), .alu_op(alu_op), .result(alu_result));

    rv_pc_unit u_pc_unit (
        .clk(clk), .reset(reset), .pc_mode(pc_mode), .branch_funct(branch_funct),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .imm(imm),
        .pc(pc), .pc_plus4(pc_plus4)
    );

    assign wb_data     = (wb_sel == WB_PC4) ? pc_plus4 : alu_result; // link or alu
    assign imem_addr   = pc;
    assign retire_we   = reg_we;
    assign retire_rd   = inst.r.rd;
    assign retire_data = wb_data;

endmodule

`default_nettype wire

/* design/rv_imm_gen.sv */
// rv_imm_gen: sign-extended immediate builder for the I, B, U and J instruction formats
`default_nettype none

module rv_imm_gen (
    input  rv_core_pkg::inst_u    inst,
    input  rv_core_pkg::imm_sel_e imm_sel,
    output logic [31:0]           imm
);
    import rv_core_pkg::*;

    logic [19:0] upper; // inst[31:12]
    logic        sign;

    assign upper = inst.u.imm;
    assign sign  = inst.u.imm[19];

    always_comb begin
        case (imm_sel)
            IMM_B: begin
                // imm[12|10:5] in funct7, imm[4:1|11] in rd
                imm = {{20{sign}}, inst.r.rd[0], inst.r.funct7[5:0], inst.r.rd[4:1], 1'b0};
            end
            IMM_U: imm = {upper, 12'b0};
            IMM_J: begin
                // imm[20|10:1|11|19:12] packed into the upper field
                imm = {{12{sign}}, upper[7:0], upper[8], upper[18:9], 1'b0};
            end
            default: imm = {{20{sign}}, inst.i.imm};
        endcase
    end

endmodule

`default_nettype wire

/* design/rv_pc_unit.sv */
// rv_pc_unit: program counter with branch condition evaluation and next-pc selection
`default_nettype none
`include "rv_core_config.svh"

module rv_pc_unit (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::pc_mode_e pc_mode,
    input  logic [2:0]            branch_funct,
    input  logic [`RV_XLEN-1:0]   rs1_data,
    input  logic [`RV_XLEN-1:0]   rs2_data,
    input  logic [`RV_XLEN-1:0]   imm,
    output logic [`RV_XLEN-1:0]   pc,
    output logic [`RV_XLEN-1:0]   pc_plus4
);
    import rv_core_pkg::*;

    logic                taken;
    logic [`RV_XLEN-1:0] pc_rel, reg_rel, next_pc;

    always_comb begin
        case (branch_funct)
            3'b000:  taken = (rs1_data == rs2_data);                   // beq
            3'b001:  taken = (rs1_data != rs2_data);                   // bne
            3'b100:  taken = ($signed(rs1_data) < $signed(rs2_data));  // blt
            3'b101:  taken = ($signed(rs1_data) >= $signed(rs2_data)); // bge
            3'b110:  taken = (rs1_data < rs2_data);                    // bltu
            3'b111:  taken = (rs1_data >= rs2_data);                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign pc_plus4 = pc + `RV_XLEN'd4;
    assign pc_rel   = pc + imm;
    assign reg_rel  = rs1_data + imm;

    always_comb begin
        case (pc_mode)
            PC_BRANCH: next_pc = taken ? pc_rel : pc_plus4;
            PC_JAL:    next_pc = pc_rel;
            PC_JALR:   next_pc = {reg_rel[`RV_XLEN-1:1], 1'b0}; // target lsb cleared
            default:   next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

/* design/rv_regfile.sv */
// rv_regfile: two-read one-write integer register file with x0 tied to zero
`default_nettype none
`include "rv_core_config.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  we,
    input  logic [4:0]            waddr,
    input  logic [4:0]            raddr1,
    input  logic [4:0]            raddr2,
    input  logic [`RV_XLEN-1:0]   wdata,
    output logic [`RV_XLEN-1:0]   rdata1,
    output logic [`RV_XLEN-1:0]   rdata2
);
    logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

    // cleared on reset so every register starts at a known value
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `RV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // combinational reads, x0 always zero
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/rv_core_pkg.sv
design/rv_alu.sv
design/rv_imm_gen.sv
design/rv_regfile.sv
design/rv_pc_unit.sv
design/rv_control.sv
design/rv_core_top.sv
tests/rv_core_assertions.sv
tests/rv_core_tb.sv

/* tests/rv_core_assertions.sv */
// rv_core_assertions: pc unit properties for the reset vector, pc alignment and sequential advance
`default_nettype none
`include "rv_core_config.svh"

module rv_core_assertions (
    input logic                  clk,
    input logic                  reset,
    input rv_core_pkg::pc_mode_e pc_mode,
    input logic [`RV_XLEN-1:0]   pc
);
    timeunit 1ns;
    timeprecision 100ps;

    import rv_core_pkg::*;

    int failures = 0; // read by the testbench at the end of the run

    // pc reloads the reset vector one edge after reset is seen
    reset_vector: assert property (@(posedge clk) reset |=> (pc == `RV_RESET_PC))
        else begin
            failures++;
            $error("pc did not load the reset vector after reset");
        end

    pc_aligned: assert property (@(posedge clk) disable iff (reset) (pc[0] == 1'b0))
        else begin
            failures++;
            $error("pc bit 0 is set");
        end

    // sequential flow moves the pc by one word
    seq_advance: assert property (@(posedge clk) disable iff (reset)
                                  (pc_mode == PC_SEQ) |=> (pc == $past(pc) + `RV_XLEN'd4))
        else begin
            failures++;
            $error("pc did not advance by four on sequential flow");
        end

endmodule

bind rv_pc_unit rv_core_assertions u_assertions (
    .clk(clk), .reset(reset), .pc_mode(pc_mode), .pc(pc)
);

`default_nettype wire

/* tests/rv_core_tb.sv */
// rv_core_tb: random RV32I instruction stream driven into the core and checked against a model
`default_nettype none
`include "rv_core_config.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_INSTR    = 3000;
    localparam int NUM_DIRECTED = 8; // zero-read adds right after reset
    localparam int TIMEOUT_NS   = (NUM_INSTR + NUM_DIRECTED + RESET_CYCLES) * CLK_PERIOD * 2;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // instruction classes of the generator
    localparam int K_OP     = 0;
    localparam int K_OP_IMM = 1;
    localparam int K_LUI    = 2;
    localparam int K_AUIPC  = 3;
    localparam int K_JAL    = 4;
    localparam int K_JALR   = 5;
    localparam int K_BRANCH = 6;
    localparam int K_NOP    = 7;

    logic        clk;
    logic        reset;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        retire_we;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] model_regs [32];
    logic [31:0] model_pc;

    // fields of the instruction on imem_data, as generated
    int          cur_kind;
    logic [4:0]  cur_rd;
    logic [4:0]  cur_rs1;
    logic [4:0]  cur_rs2;
    logic [2:0]  cur_f3;
    logic        cur_alt;
    logic [31:0] cur_imm;

    integer seed;
    int     mismatches;
    int     checks;

    rv_core_top u_dut (
        .clk(clk), .reset(reset), .imem_data(imem_data), .imem_addr(imem_addr),
        .retire_we(retire_we), .retire_rd(retire_rd), .retire_data(retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            mismatches++;
            $display("MISMATCH %s at %0t ns: got 0x%08h, expected 0x%08h",
                     name, $time, got, expected);
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: begin
                if (alt) begin
                    return a - b;
                end
                return a + b;
            end
            3'b001:  return a << sh;
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> sh; // arithmetic, sign fills
                end
                return a >> sh;
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            3'b111:  return a >= b;
            default: return 1'b0; // reserved funct3, never taken
        endcase
    endfunction

    task automatic model_reset();
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'h0;
        end
        model_pc = `RV_RESET_PC;
    endtask

    // add with sources that nobody wrote yet, so the sum must be zero
    task automatic set_zero_read_add(input int idx);
        cur_kind  = K_OP;
        cur_rd    = 5'(idx + 1);
        cur_rs1   = 5'(31 - idx);
        cur_rs2   = 5'(30 - idx);
        cur_f3    = 3'b000;
        cur_alt   = 1'b0;
        cur_imm   = 32'h0;
        imem_data = {7'b0, cur_rs2, cur_rs1, cur_f3, cur_rd, OPC_OP};
    endtask

    task automatic gen_instruction();
        logic [31:0] r;
        int          pick;
        logic [6:0]  nop_opc;
        pick    = {$random(seed)} % 100;
        r       = $random(seed);
        cur_rd  = r[4:0];
        cur_rs1 = r[9:5];
        cur_rs2 = r[14:10];
        cur_f3  = r[17:15];
        cur_alt = r[18];
        cur_imm = 32'h0;
        if (r[21:20] == 2'b00) begin
            cur_rs2 = cur_rs1; // equal operands now and then
        end
        r = $random(seed);
        if (pick < 25) begin
            cur_kind  = K_OP;
            cur_alt   = cur_alt && (cur_f3 == 3'b000 || cur_f3 == 3'b101);
            imem_data = {1'b0, cur_alt, 5'b0, cur_rs2, cur_rs1, cur_f3, cur_rd, OPC_OP};
        end else if (pick < 50) begin
            cur_kind = K_OP_IMM;
            if (cur_f3 == 3'b001 || cur_f3 == 3'b101) begin
                cur_alt   = cur_alt && (cur_f3 == 3'b101);
                cur_imm   = {27'b0, r[4:0]};
                imem_data = {1'b0, cur_alt, 5'b0, r[4:0], cur_rs1, cur_f3, cur_rd, OPC_OP_IMM};
            end else begin
                cur_alt   = 1'b0;
                cur_imm   = {{20{r[11]}}, r[11:0]};
                imem_data = {r[11:0], cur_rs1, cur_f3, cur_rd, OPC_OP_IMM};
            end
        end else if (pick < 58) begin
            cur_kind  = K_LUI;
            cur_imm   = {r[31:12], 12'b0};
            imem_data = {r[31:12], cur_rd, OPC_LUI};
        end else if (pick < 64) begin
            cur_kind  = K_AUIPC;
            cur_imm   = {r[31:12], 12'b0};
            imem_data = {r[31:12], cur_rd, OPC_AUIPC};
        end else if (pick < 70) begin
            cur_kind  = K_JAL;
            cur_imm   = {{11{r[20]}}, r[20:1], 1'b0};
            imem_data = {cur_imm[20], cur_imm[10:1], cur_imm[11], cur_imm[19:12],
                         cur_rd, OPC_JAL};
        end else if (pick < 76) begin
            cur_kind  = K_JALR;
            cur_imm   = {{20{r[11]}}, r[11:0]};
            imem_data = {r[11:0], cur_rs1, 3'b000, cur_rd, OPC_JALR};
        end else if (pick < 92) begin
            cur_kind  = K_BRANCH;
            cur_imm   = {{19{r[12]}}, r[12:1], 1'b0};
            imem_data = {cur_imm[12], cur_imm[10:5], cur_rs2, cur_rs1, cur_f3,
                         cur_imm[4:1], cur_imm[11], OPC_BRANCH};
        end else begin
            cur_kind = K_NOP;
            case (r[13:12])
                2'b00:   nop_opc = 7'b0000011; // load
                2'b01:   nop_opc = 7'b0100011; // store
                2'b10:   nop_opc = 7'b1110011; // system
                default: nop_opc = 7'b0001111; // fence
            endcase
            imem_data = {r[31:7], nop_opc};
        end
    endtask

    // what the current instruction should retire and where the pc goes next
    task automatic model_step(output logic exp_we, output logic [31:0] exp_data,
                              output logic [31:0] next_pc);
        logic [31:0] a;
        logic [31:0] b;
        logic        writes;
        a        = model_regs[cur_rs1];
        b        = model_regs[cur_rs2];
        writes   = 1'b1;
        exp_data = 32'h0;
        next_pc  = model_pc + 32'd4;
        case (cur_kind)
            K_OP:     exp_data = alu_ref(cur_f3, cur_alt, a, b);
            K_OP_IMM: exp_data = alu_ref(cur_f3, cur_alt, a, cur_imm);
            K_LUI:    exp_data = cur_imm;
            K_AUIPC:  exp_data = model_pc + cur_imm;
            K_JAL: begin
                exp_data = model_pc + 32'd4;
                next_pc  = model_pc + cur_imm;
            end
            K_JALR: begin
                exp_data = model_pc + 32'd4;
                next_pc  = (a + cur_imm) & 32'hffff_fffe;
            end
            K_BRANCH: begin
                writes = 1'b0;
                if (branch_taken(cur_f3, a, b)) begin
                    next_pc = model_pc + cur_imm;
                end
            end
            default: writes = 1'b0;
        endcase
        exp_we = writes && (cur_rd != 5'd0);
    endtask

    task automatic check_and_commit();
        logic        exp_we;
        logic [31:0] exp_data;
        logic [31:0] next_pc;
        model_step(exp_we, exp_data, next_pc);
        #(2); // retire outputs settled, well before the rising edge
        check_value("retire_we", {31'b0, retire_we}, {31'b0, exp_we});
        if (exp_we) begin
            check_value("retire_rd", {27'b0, retire_rd}, {27'b0, cur_rd});
            check_value("retire_data", retire_data, exp_data);
            model_regs[cur_rd] = exp_data;
        end
        model_pc = next_pc;
    endtask

    initial begin
        int assert_failures;
        seed       = 36;
        mismatches = 0;
        checks     = 0;
        reset      = 1'b1;
        imem_data  = {7'b0, 5'd2, 5'd1, 3'b000, 5'd5, OPC_OP}; // add x5, x1, x2 held in reset
        model_reset();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_value("imem_addr", imem_addr, `RV_RESET_PC);
            check_value("retire_we", {31'b0, retire_we}, 32'h0);
        end
        reset = 1'b0;
        for (int i = 0; i < NUM_DIRECTED + NUM_INSTR; i++) begin
            check_value("imem_addr", imem_addr, model_pc);
            if (i < NUM_DIRECTED) begin
                set_zero_read_add(i);
            end else begin
                gen_instruction();
            end
            check_and_commit();
            @(negedge clk);
        end
        check_value("imem_addr", imem_addr, model_pc);
        assert_failures = u_dut.u_pc_unit.u_assertions.failures;
        $display("errors: %0d mismatches, %0d assertion failures, in %0d checks",
                 mismatches, assert_failures, checks);
        if (mismatches == 0 && assert_failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // watchdog, twice the expected run length
    initial begin
        #(TIMEOUT_NS);
        $display("ERROR: the run timed out after %0d ns with %0d mismatches so far",
                 TIMEOUT_NS, mismatches);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
